// ==== vlog.f ====
+incdir+.
soc_pkg.sv
bus_arbiter.sv
addr_decoder.sv
bram.sv
uart.sv
clint.sv
soc.sv
tb_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_soc -o tb_soc
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi

exit 0

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc;

  localparam int CPB          = `SOC_UART_CLKS_PER_BIT;
  localparam int FRAME_CYCLES = 10 * CPB;
  localparam int REQ_LIMIT    = 20; // cycles a single request may wait for ready
  // writes and read-back, shared bus rounds, unmapped, three frames, clint with mtip wait
  localparam int TEST_CYCLES  = (64 + 16) * 5 + 8 * 10 + 4 * 5 + 3 * (FRAME_CYCLES + 30)
                                + 8 * 5 + 250;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES * 10;

  logic        clk;
  logic        arst_n;
  logic        f_valid;
  logic        f_instr;
  logic [31:0] f_addr;
  logic [31:0] f_wdata;
  logic [3:0]  f_wstrb;
  logic [31:0] f_rdata;
  logic        f_ready;
  logic        d_valid;
  logic        d_instr;
  logic [31:0] d_addr;
  logic [31:0] d_wdata;
  logic [3:0]  d_wstrb;
  logic [31:0] d_rdata;
  logic        d_ready;
  logic        tx;
  logic        msip;
  logic        mtip;

  int          err_cnt;
  int          check_cnt;
  logic [31:0] lcg_state;
  logic [31:0] ref_mem [int]; // bram words written so far, by word index
  logic [9:0]  pool [16];
  logic [31:0] cmp_addr_q [$];
  logic [31:0] cmp_data_q [$];
  logic        cmp_instr_q [$];
  logic [7:0]  uart_exp_q [$];
  logic [7:0]  uart_rx_q [$];
  event        read_done;

  soc dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .f_valid (f_valid),
    .f_instr (f_instr),
    .f_addr  (f_addr),
    .f_wdata (f_wdata),
    .f_wstrb (f_wstrb),
    .f_rdata (f_rdata),
    .f_ready (f_ready),
    .d_valid (d_valid),
    .d_instr (d_instr),
    .d_addr  (d_addr),
    .d_wdata (d_wdata),
    .d_wstrb (d_wstrb),
    .d_rdata (d_rdata),
    .d_ready (d_ready),
    .tx      (tx),
    .msip    (msip),
    .mtip    (mtip)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // expected read data from the address map and the bram contents
  function automatic logic [31:0] expect_read(logic [31:0] addr, logic instr);
    int idx;
    idx = int'(addr[11:2]);
    if (addr >= `SOC_BRAM_BASE && addr < `SOC_BRAM_TOP) begin
      return ref_mem.exists(idx) ? ref_mem[idx] : 32'h0;
    end
    if (!instr && addr >= `SOC_UART_BASE && addr < `SOC_UART_TOP) begin
      return 32'h0; // peer registers are checked where they are read
    end
    if (!instr && addr >= `SOC_CLINT_BASE && addr < `SOC_CLINT_TOP) begin
      return 32'h0;
    end
    return `SOC_UNMAPPED_RDATA; // fetches only reach bram
  endfunction

  function automatic void model_write(logic [31:0] addr, logic [31:0] wdata, logic [3:0] wstrb);
    int          idx;
    logic [31:0] word;
    idx  = int'(addr[11:2]);
    word = ref_mem.exists(idx) ? ref_mem[idx] : 32'h0;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    ref_mem[idx] = word;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    rdata = 32'h0;
    @(negedge clk);
    d_valid = 1'b1;
    d_addr  = addr;
    d_wdata = wdata;
    d_wstrb = wstrb;
    @(negedge clk);
    waited = 1;
    while (!d_ready && waited < REQ_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (d_ready) begin
      rdata = d_rdata;
    end else begin
      $display("data port got no ready for address 0x%08h", addr);
      err_cnt++;
    end
    d_valid = 1'b0;
  endtask

  task automatic fetch_read(input logic [31:0] addr, output logic [31:0] rdata);
    int waited;
    rdata = 32'h0;
    @(negedge clk);
    f_valid = 1'b1;
    f_addr  = addr;
    @(negedge clk);
    waited = 1;
    while (!f_ready && waited < REQ_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (f_ready) begin
      rdata = f_rdata;
    end else begin
      $display("fetch port got no ready for address 0x%08h", addr);
      err_cnt++;
    end
    f_valid = 1'b0;
  endtask

  task automatic queue_read(input logic [31:0] addr, input logic instr, input logic [31:0] data);
    cmp_addr_q.push_back(addr);
    cmp_instr_q.push_back(instr);
    cmp_data_q.push_back(data);
    -> read_done;
  endtask

  // compares every queued read with the reference model
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic        instr;
    forever begin
      @(read_done);
      while (cmp_addr_q.size() != 0) begin
        addr  = cmp_addr_q.pop_front();
        data  = cmp_data_q.pop_front();
        instr = cmp_instr_q.pop_front();
        check(instr ? "f_rdata" : "d_rdata", data, expect_read(addr, instr));
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (arst_n && f_ready && d_ready) begin
        $display("both ports saw ready in the same cycle at %0t", $time);
        err_cnt++;
      end
    end
  end

  // rebuilds each frame on tx, sampling at mid-bit
  initial begin
    logic [7:0] rx_byte;
    forever begin
      @(negedge tx);
      repeat (CPB / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        $display("tx start bit did not hold low at %0t", $time);
        err_cnt++;
      end
      for (int b = 0; b < 8; b++) begin
        repeat (CPB) @(negedge clk);
        rx_byte[b] = tx;
      end
      repeat (CPB) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("tx stop bit missing at %0t", $time);
        err_cnt++;
      end
      uart_rx_q.push_back(rx_byte);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("errors: %0d", err_cnt);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] rd_f;
    logic [31:0] rd_d;
    logic [31:0] fa;
    logic [31:0] da;
    logic [31:0] addr;
    logic [31:0] r;
    logic [3:0]  strb;
    logic [63:0] cmp;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] msip_vals [4];
    int          waited;
    err_cnt   = 0;
    check_cnt = 0;
    lcg_state = 32'd78;
    arst_n    = 1'b0;
    f_valid   = 1'b0;
    f_instr   = 1'b1;
    f_addr    = 32'h0;
    f_wdata   = 32'h0;
    f_wstrb   = 4'h0;
    d_valid   = 1'b0;
    d_instr   = 1'b0;
    d_addr    = 32'h0;
    d_wdata   = 32'h0;
    d_wstrb   = 4'h0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    check("tx", tx, 1);
    check("msip", msip, 0);
    check("mtip", mtip, 0);
    check("f_ready", f_ready, 0);
    check("d_ready", d_ready, 0);

    for (int i = 0; i < 16; i++) begin
      r = lcg_next();
      pool[i] = r[25:16];
    end
    for (int i = 0; i < 64; i++) begin
      r    = lcg_next();
      addr = {20'h0, pool[r[19:16]], 2'b00};
      strb = r[27:24];
      if (strb == 4'h0 || !ref_mem.exists(int'(addr[11:2]))) begin
        strb = 4'hF; // a fresh word gets all its bytes
      end
      r = lcg_next();
      model_write(addr, r, strb);
      data_access(addr, r, strb, rd);
    end
    for (int i = 0; i < 16; i++) begin
      addr = {20'h0, pool[i], 2'b00};
      data_access(addr, 32'h0, 4'h0, rd);
      queue_read(addr, 1'b0, rd);
    end

    for (int i = 0; i < 8; i++) begin
      r  = lcg_next();
      fa = {20'h0, pool[r[19:16]], 2'b00};
      da = {20'h0, pool[r[23:20]], 2'b00};
      fork
        begin
          fetch_read(fa, rd_f);
          queue_read(fa, 1'b1, rd_f);
        end
        begin
          data_access(da, 32'h0, 4'h0, rd_d);
          queue_read(da, 1'b0, rd_d);
        end
      join
    end

    r    = lcg_next();
    addr = 32'h2000_0000 + {20'h0, r[11:2], 2'b00};
    data_access(addr, 32'h0, 4'h0, rd);
    queue_read(addr, 1'b0, rd);
    fetch_read(`SOC_UART_BASE + 32'h4, rd);
    queue_read(`SOC_UART_BASE + 32'h4, 1'b1, rd);
    addr = 32'h3000_0000 | {20'h0, pool[0], 2'b00}; // aliases a bram word in its low bits
    data_access(addr, lcg_next(), 4'hF, rd);
    addr = {20'h0, pool[0], 2'b00};
    data_access(addr, 32'h0, 4'h0, rd);
    queue_read(addr, 1'b0, rd);

    for (int n = 0; n < 3; n++) begin
      waited = 0;
      data_access(`SOC_UART_BASE + 32'h4, 32'h0, 4'h0, rd);
      while (rd[0] && waited < 2 * FRAME_CYCLES) begin
        data_access(`SOC_UART_BASE + 32'h4, 32'h0, 4'h0, rd);
        waited++;
      end
      if (rd[0]) begin
        $display("uart status never went idle before byte %0d", n);
        err_cnt++;
      end
      r = lcg_next();
      uart_exp_q.push_back(r[15:8]);
      data_access(`SOC_UART_BASE, {24'h0, r[15:8]}, 4'b0001, rd);
      data_access(`SOC_UART_BASE + 32'h4, 32'h0, 4'h0, rd);
      check("uart_status", rd, 1);
    end
    waited = 0;
    while (uart_rx_q.size() < 3 && waited < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (uart_rx_q.size() < 3) begin
      $display("only %0d of 3 uart frames were seen on tx", uart_rx_q.size());
      err_cnt++;
    end
    for (int n = 0; n < uart_rx_q.size() && n < 3; n++) begin
      check("tx_byte", uart_rx_q[n], uart_exp_q[n]);
    end

    msip_vals[0] = 32'h0000_0001;
    msip_vals[1] = 32'hFFFF_FFFE;
    msip_vals[2] = 32'h0000_0003;
    msip_vals[3] = 32'h0000_0000;
    for (int i = 0; i < 4; i++) begin
      data_access(`SOC_CLINT_BASE, msip_vals[i], 4'hF, rd);
      check("msip", msip, msip_vals[i][0]);
    end
    data_access(`SOC_CLINT_BASE + 32'hBFF8, 32'h0, 4'h0, lo);
    data_access(`SOC_CLINT_BASE + 32'hBFFC, 32'h0, 4'h0, hi);
    cmp = {hi, lo} + 64'd200;
    data_access(`SOC_CLINT_BASE + 32'h4000, cmp[31:0], 4'hF, rd);
    data_access(`SOC_CLINT_BASE + 32'h4004, cmp[63:32], 4'hF, rd);
    check("mtip", mtip, 0);
    waited = 0;
    while (!mtip && waited < 400) begin
      @(negedge clk);
      waited++;
    end
    if (!mtip) begin
      $display("mtip did not rise after mtimecmp was set 200 cycles ahead");
      err_cnt++;
    end

    repeat (5) @(negedge clk);
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== soc.sv ====
`timescale 1ns/1ps

module soc (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           f_valid,
  input  logic           f_instr,
  input  soc_pkg::addr_t f_addr,
  input  soc_pkg::data_t f_wdata,
  input  soc_pkg::strb_t f_wstrb,
  output soc_pkg::data_t f_rdata,
  output logic           f_ready,
  input  logic           d_valid,
  input  logic           d_instr,
  input  soc_pkg::addr_t d_addr,
  input  soc_pkg::data_t d_wdata,
  input  soc_pkg::strb_t d_wstrb,
  output soc_pkg::data_t d_rdata,
  output logic           d_ready,
  output logic           tx,
  output logic           msip,
  output logic           mtip
);
  import soc_pkg::*;

  logic  bus_valid;
  logic  bus_instr;
  addr_t bus_addr;
  data_t bus_wdata;
  strb_t bus_wstrb;
  data_t bus_rdata;
  logic  bus_ready;

  addr_t per_addr;
  data_t per_wdata;
  strb_t per_wstrb;

  logic  bram_valid;
  data_t bram_rdata;
  logic  bram_ready;
  logic  uart_valid;
  data_t uart_rdata;
  logic  uart_ready;
  logic  clint_valid;
  data_t clint_rdata;
  logic  clint_ready;

  bus_arbiter arbiter_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .f_valid   (f_valid),
    .f_instr   (f_instr),
    .f_addr    (f_addr),
    .f_wdata   (f_wdata),
    .f_wstrb   (f_wstrb),
    .f_rdata   (f_rdata),
    .f_ready   (f_ready),
    .d_valid   (d_valid),
    .d_instr   (d_instr),
    .d_addr    (d_addr),
    .d_wdata   (d_wdata),
    .d_wstrb   (d_wstrb),
    .d_rdata   (d_rdata),
    .d_ready   (d_ready),
    .bus_valid (bus_valid),
    .bus_instr (bus_instr),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wstrb (bus_wstrb),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready)
  );

  addr_decoder decoder_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .bus_valid   (bus_valid),
    .bus_instr   (bus_instr),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_wstrb   (bus_wstrb),
    .bus_rdata   (bus_rdata),
    .bus_ready   (bus_ready),
    .bram_valid  (bram_valid),
    .uart_valid  (uart_valid),
    .clint_valid (clint_valid),
    .per_addr    (per_addr),
    .per_wdata   (per_wdata),
    .per_wstrb   (per_wstrb),
    .bram_rdata  (bram_rdata),
    .bram_ready  (bram_ready),
    .uart_rdata  (uart_rdata),
    .uart_ready  (uart_ready),
    .clint_rdata (clint_rdata),
    .clint_ready (clint_ready)
  );

  bram bram_i (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (bram_valid),
    .addr   (per_addr),
    .wdata  (per_wdata),
    .wstrb  (per_wstrb),
    .rdata  (bram_rdata),
    .ready  (bram_ready)
  );

  uart uart_i (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (uart_valid),
    .addr   (per_addr),
    .wdata  (per_wdata),
    .wstrb  (per_wstrb),
    .rdata  (uart_rdata),
    .ready  (uart_ready),
    .tx     (tx)
  );

  clint clint_i (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (clint_valid),
    .addr   (per_addr),
    .wdata  (per_wdata),
    .wstrb  (per_wstrb),
    .rdata  (clint_rdata),
    .ready  (clint_ready),
    .msip   (msip),
    .mtip   (mtip)
  );

endmodule

// ==== clint.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module clint (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           valid,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::data_t wdata,
  input  soc_pkg::strb_t wstrb,
  output soc_pkg::data_t rdata,
  output logic           ready,
  output logic           msip,
  output logic           mtip
);
  import soc_pkg::*;

  localparam logic [15:0] MSIP_OFF     = 16'h0000;
  localparam logic [15:0] MTIMECMP_LO  = 16'h4000;
  localparam logic [15:0] MTIMECMP_HI  = 16'h4004;
  localparam logic [15:0] MTIME_LO     = 16'hBFF8;
  localparam logic [15:0] MTIME_HI     = 16'hBFFC;

  time_t       mtime;
  time_t       mtimecmp;
  logic [15:0] off;
  logic        access;
  logic        wr;

  function automatic data_t merge(data_t cur, data_t nxt, strb_t strb);
    data_t res;
    res = cur;
    for (int b = 0; b < `SOC_DATA_W/8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = nxt[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign off    = addr[15:0];
  assign access = valid && !ready;
  assign wr     = access && (wstrb != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready    <= 1'b0;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1; // no timer interrupt until software sets a compare value
    end else begin
      ready <= access;
      mtime <= mtime + 1'b1;
      mtip  <= (mtime >= mtimecmp);
      if (wr) begin
        case (off)
          MSIP_OFF: begin
            if (wstrb[0]) begin
              msip <= wdata[0];
            end
          end
          MTIMECMP_LO: begin
            mtimecmp[`SOC_DATA_W-1:0] <= merge(mtimecmp[`SOC_DATA_W-1:0], wdata, wstrb);
          end
          MTIMECMP_HI: begin
            mtimecmp[2*`SOC_DATA_W-1:`SOC_DATA_W] <=
              merge(mtimecmp[2*`SOC_DATA_W-1:`SOC_DATA_W], wdata, wstrb);
          end
          default: ; // mtime is read only
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (off)
        MSIP_OFF:    rdata <= {{(`SOC_DATA_W-1){1'b0}}, msip};
        MTIMECMP_LO: rdata <= mtimecmp[`SOC_DATA_W-1:0];
        MTIMECMP_HI: rdata <= mtimecmp[2*`SOC_DATA_W-1:`SOC_DATA_W];
        MTIME_LO:    rdata <= mtime[`SOC_DATA_W-1:0];
        MTIME_HI:    rdata <= mtime[2*`SOC_DATA_W-1:`SOC_DATA_W];
        default:     rdata <= '0;
      endcase
    end
  end

endmodule

// ==== uart.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module uart (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           valid,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::data_t wdata,
  input  soc_pkg::strb_t wstrb,
  output soc_pkg::data_t rdata,
  output logic           ready,
  output logic           tx
);
  import soc_pkg::*;

  localparam int DIV_W = $clog2(`SOC_UART_CLKS_PER_BIT + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SOC_UART_CLKS_PER_BIT - 1);

  uart_state_e      state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift_q;
  logic             access;
  logic             busy;
  logic             tx_start;
  logic             bit_end;

  assign access   = valid && !ready;
  assign busy     = (state != UART_IDLE);
  // a write to the data register while busy is dropped
  assign tx_start = access && (addr[3:2] == 2'd0) && wstrb[0] && !busy;
  assign bit_end  = (div_cnt == DIV_LAST);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= (addr[3:2] == 2'd1) ? {{(`SOC_DATA_W-1){1'b0}}, busy} : '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= UART_IDLE;
      tx      <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (state == UART_IDLE) begin
      if (tx_start) begin
        state   <= UART_START;
        tx      <= 1'b0; // start bit
        div_cnt <= '0;
      end
    end else if (!bit_end) begin
      div_cnt <= div_cnt + 1'b1;
    end else begin
      div_cnt <= '0;
      case (state)
        UART_START: begin
          state   <= UART_DATA;
          tx      <= shift_q[0];
          bit_cnt <= '0;
        end
        UART_DATA: begin
          if (bit_cnt == 3'd7) begin
            state <= UART_STOP;
            tx    <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            tx      <= shift_q[0];
          end
        end
        default: state <= UART_IDLE; // end of the stop bit
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_start) begin
      shift_q <= wdata[7:0];
    end else if (bit_end && (state == UART_START || state == UART_DATA)) begin
      shift_q <= shift_q >> 1; // lsb first
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!arst_n) (state == UART_IDLE) |-> tx);

endmodule

// ==== bram.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module bram (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           valid,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::data_t wdata,
  input  soc_pkg::strb_t wstrb,
  output soc_pkg::data_t rdata,
  output logic           ready
);
  import soc_pkg::*;

  localparam int IDX_W = $clog2(`SOC_BRAM_WORDS);

  data_t            mem [`SOC_BRAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             access;

  assign idx    = addr[IDX_W+1:2]; // byte address to word index
  assign access = valid && !ready; // no second access in the ready cycle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      for (int b = 0; b < `SOC_DATA_W/8; b++) begin
        if (wstrb[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      rdata <= mem[idx]; // old contents on a write
    end
  end

endmodule

// ==== addr_decoder.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module addr_decoder (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           bus_valid,
  input  logic           bus_instr,
  input  soc_pkg::addr_t bus_addr,
  input  soc_pkg::data_t bus_wdata,
  input  soc_pkg::strb_t bus_wstrb,
  output soc_pkg::data_t bus_rdata,
  output logic           bus_ready,
  output logic           bram_valid,
  output logic           uart_valid,
  output logic           clint_valid,
  output soc_pkg::addr_t per_addr,
  output soc_pkg::data_t per_wdata,
  output soc_pkg::strb_t per_wstrb,
  input  soc_pkg::data_t bram_rdata,
  input  logic           bram_ready,
  input  soc_pkg::data_t uart_rdata,
  input  logic           uart_ready,
  input  soc_pkg::data_t clint_rdata,
  input  logic           clint_ready
);
  import soc_pkg::*;

  logic  bram_hit;
  logic  uart_hit;
  logic  clint_hit;
  logic  unmapped_ready;
  addr_t base;

  // instruction fetches are only served from bram
  assign bram_hit  = (bus_addr >= `SOC_BRAM_BASE) && (bus_addr < `SOC_BRAM_TOP);
  assign uart_hit  = !bus_instr && (bus_addr >= `SOC_UART_BASE) && (bus_addr < `SOC_UART_TOP);
  assign clint_hit = !bus_instr && (bus_addr >= `SOC_CLINT_BASE) && (bus_addr < `SOC_CLINT_TOP);

  assign bram_valid  = bus_valid && bram_hit;
  assign uart_valid  = bus_valid && uart_hit;
  assign clint_valid = bus_valid && clint_hit;

  always_comb begin
    if (clint_hit) begin
      base = `SOC_CLINT_BASE;
    end else if (uart_hit) begin
      base = `SOC_UART_BASE;
    end else begin
      base = `SOC_BRAM_BASE;
    end
  end

  assign per_addr  = bus_addr - base;
  assign per_wdata = bus_wdata;
  assign per_wstrb = bus_wstrb;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= bus_valid && !(bram_hit || uart_hit || clint_hit) && !unmapped_ready;
    end
  end

  always_comb begin
    if (bram_ready) begin
      bus_rdata = bram_rdata;
      bus_ready = 1'b1;
    end else if (uart_ready) begin
      bus_rdata = uart_rdata;
      bus_ready = 1'b1;
    end else if (clint_ready) begin
      bus_rdata = clint_rdata;
      bus_ready = 1'b1;
    end else if (unmapped_ready) begin
      bus_rdata = `SOC_UNMAPPED_RDATA;
      bus_ready = 1'b1;
    end else begin
      bus_rdata = '0;
      bus_ready = 1'b0;
    end
  end

  a_one_peer: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({bram_valid, uart_valid, clint_valid}));

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           f_valid,
  input  logic           f_instr,
  input  soc_pkg::addr_t f_addr,
  input  soc_pkg::data_t f_wdata,
  input  soc_pkg::strb_t f_wstrb,
  output soc_pkg::data_t f_rdata,
  output logic           f_ready,
  input  logic           d_valid,
  input  logic           d_instr,
  input  soc_pkg::addr_t d_addr,
  input  soc_pkg::data_t d_wdata,
  input  soc_pkg::strb_t d_wstrb,
  output soc_pkg::data_t d_rdata,
  output logic           d_ready,
  output logic           bus_valid,
  output logic           bus_instr,
  output soc_pkg::addr_t bus_addr,
  output soc_pkg::data_t bus_wdata,
  output soc_pkg::strb_t bus_wstrb,
  input  soc_pkg::data_t bus_rdata,
  input  logic           bus_ready
);
  import soc_pkg::*;

  arb_state_e state;
  logic       grant_d; // the data port owns the bus
  logic       prio_d;  // the data port wins the next tie
  logic       pick_d;
  logic       busy;

  assign pick_d = d_valid && (!f_valid || prio_d);
  assign busy   = (state == ARB_BUSY);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ARB_IDLE;
      grant_d <= 1'b0;
      prio_d  <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (f_valid || d_valid) begin
            state   <= ARB_BUSY;
            grant_d <= pick_d;
          end
        end
        ARB_BUSY: begin
          if (bus_ready) begin
            state  <= ARB_IDLE;
            prio_d <= !grant_d; // the other port goes first next time
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  assign bus_valid = busy && (grant_d ? d_valid : f_valid);
  assign bus_instr = grant_d ? d_instr : f_instr;
  assign bus_addr  = grant_d ? d_addr  : f_addr;
  assign bus_wdata = grant_d ? d_wdata : f_wdata;
  assign bus_wstrb = grant_d ? d_wstrb : f_wstrb;

  assign f_ready = busy && !grant_d && bus_ready;
  assign d_ready = busy && grant_d && bus_ready;
  assign f_rdata = grant_d ? '0 : bus_rdata;
  assign d_rdata = grant_d ? bus_rdata : '0;

  // a response from the decoder is only expected while a request owns the bus
  a_ready_in_busy: assert property (@(posedge clk) disable iff (!arst_n) bus_ready |-> busy);

endmodule

// ==== soc_pkg.sv ====
`include "soc_config.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [`SOC_DATA_W/8-1:0] strb_t; // one enable per byte lane

  typedef logic [2*`SOC_DATA_W-1:0] time_t; // mtime and mtimecmp span two words

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// address map, top addresses are exclusive
`define SOC_BRAM_BASE  32'h0000_0000
`define SOC_BRAM_TOP   32'h0000_1000
`define SOC_UART_BASE  32'h1000_0000
`define SOC_UART_TOP   32'h1000_0010
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_TOP  32'h0200_C000

`define SOC_BRAM_WORDS 1024 // must cover the whole bram range

`define SOC_UART_CLKS_PER_BIT 8

`define SOC_UNMAPPED_RDATA 32'hDEAD_BEEF

`endif
